//--- Bender.yml
package:
  name: riscv_em

sources:
  - files:
      - verilog/riscv_em_pkg.sv
      - verilog/riscv_exec_stage.sv
      - verilog/riscv_ppreg.sv
      - verilog/riscv_mem_stage.sv
      - verilog/riscv_wb_stage.sv
      - verilog/riscv_em_top.sv
  - target: test
    files:
      - verification/riscv_em_tb.sv

//--- verification/riscv_em_tb.sv
`timescale 1ns/1ps

module riscv_em_tb;

    localparam int N_INSTR     = 200 + 200 + 3 * 40 + 200;
    localparam int CYCLE_LIMIT = 4 * N_INSTR + 100;

    typedef struct packed {
        logic        regw;
        logic [4:0]  rdaddr;
        logic [63:0] rddata;
        logic [63:0] pc;
        logic        trap;
        logic [3:0]  cause;
    } exp_t;

    logic        clk;
    logic        rst;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [63:0] rs1data;
    logic [63:0] rs2data;
    logic [63:0] imm;
    logic [63:0] pc;
    logic [4:0]  rdaddr;
    logic        stall;
    logic        flush;
    logic        retire;
    logic        regw;
    logic [4:0]  rdaddr_o;
    logic [63:0] rddata;
    logic        trap;
    logic [3:0]  cause;
    logic [63:0] pc_o;

    integer      seed;
    int          cycle_cnt;
    int          err_cnt;
    int          ret_cnt;
    int          err_mark;
    int          ret_mark;
    logic        kill_pending;  // last accepted instruction traps
    logic [63:0] pc_next;
    logic [63:0] last_st_addr;
    logic [7:0]  ref_mem [512];
    exp_t        exp_q [$];

    riscv_em_top #(.DMEM_DEPTH(64)) DUT (
        .i_riscv_em_clk     (clk),
        .i_riscv_em_rst     (rst),
        .i_riscv_em_opcode  (opcode),
        .i_riscv_em_funct3  (funct3),
        .i_riscv_em_rs1data (rs1data),
        .i_riscv_em_rs2data (rs2data),
        .i_riscv_em_imm     (imm),
        .i_riscv_em_pc      (pc),
        .i_riscv_em_rdaddr  (rdaddr),
        .i_riscv_em_stall   (stall),
        .i_riscv_em_flush   (flush),
        .o_riscv_em_retire  (retire),
        .o_riscv_em_regw    (regw),
        .o_riscv_em_rdaddr  (rdaddr_o),
        .o_riscv_em_rddata  (rddata),
        .o_riscv_em_trap    (trap),
        .o_riscv_em_cause   (cause),
        .o_riscv_em_pc      (pc_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic [63:0] a,
                                            input logic [63:0] b);
        case (f3)
            3'd0:    return a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3:    return (a < b) ? 64'd1 : 64'd0;
            3'd4:    return a ^ b;
            3'd5:    return a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // outputs are stable since the last rising edge
    task automatic observe(input logic stall_next);
        exp_t e;
        if (retire && !stall_next)
        begin
            if (exp_q.size() == 0)
            begin
                $display("unexpected retirement of pc %h at %0t ns", pc_o, $time);
                err_cnt++;
            end
            else
            begin
                e = exp_q.pop_front();
                ret_cnt++;
                check_val("pc", pc_o, e.pc);
                check_val("regw", regw, e.regw);
                check_val("trap", trap, e.trap);
                if (e.trap)
                    check_val("cause", cause, e.cause);
                if (e.regw)
                begin
                    check_val("rdaddr", rdaddr_o, e.rdaddr);
                    check_val("rddata", rddata, e.rddata);
                end
            end
        end
    endtask

    task automatic model_accept(input logic [6:0] opc, input logic [2:0] f3,
                                input logic [63:0] rs1, input logic [63:0] rs2,
                                input logic [63:0] imm_v, input logic [63:0] pc_v,
                                input logic [4:0] rd, input logic fl);
        exp_t        e;
        logic [63:0] addr;
        int          nbytes;
        int          base;
        logic        known;
        logic        is_mem;
        known  = (opc == riscv_em_pkg::OPC_OP) || (opc == riscv_em_pkg::OPC_OPIMM) ||
                 (opc == riscv_em_pkg::OPC_LOAD) || (opc == riscv_em_pkg::OPC_STORE) ||
                 (opc == riscv_em_pkg::OPC_LUI) || (opc == riscv_em_pkg::OPC_JAL);
        is_mem = (opc == riscv_em_pkg::OPC_LOAD) || (opc == riscv_em_pkg::OPC_STORE);
        e        = '0;
        e.pc     = pc_v;
        e.rdaddr = rd;
        e.regw   = (rd != 5'd0);
        addr     = rs1 + imm_v;
        nbytes   = 1 << f3[1:0];
        base     = int'(addr[8:0]);  // 64 doublewords of data memory
        if (fl || kill_pending || !known)
        begin
            kill_pending = 1'b0;  // enters as a bubble
        end
        else
        begin
            if (opc == riscv_em_pkg::OPC_LUI)
                e.rddata = imm_v;
            else if (opc == riscv_em_pkg::OPC_JAL)
                e.rddata = pc_v + 64'd4;
            else if (!is_mem)
                e.rddata = alu_ref(f3, rs1, (opc == riscv_em_pkg::OPC_OP) ? rs2 : imm_v);
            else
            begin
                e.trap = (addr & (nbytes - 1)) != 0;
                if (e.trap)
                begin
                    e.regw  = 1'b0;
                    e.cause = (opc == riscv_em_pkg::OPC_LOAD) ? 4'd4 : 4'd6;
                end
                else if (opc == riscv_em_pkg::OPC_STORE)
                begin
                    e.regw = 1'b0;
                    for (int k = 0; k < nbytes; k++)
                        ref_mem[base + k] = rs2[8*k +: 8];
                end
                else
                begin
                    for (int k = 0; k < nbytes; k++)
                        e.rddata[8*k +: 8] = ref_mem[base + k];
                    if (!f3[2])
                    begin
                        for (int k = 8 * nbytes; k < 64; k++)
                            e.rddata[k] = e.rddata[8*nbytes-1];
                    end
                end
            end
            kill_pending = e.trap;
            exp_q.push_back(e);
        end
    endtask

    // inputs stay steady through the stalled edges, then one accepting edge
    task automatic issue(input logic [6:0] opc, input logic [2:0] f3, input logic [63:0] rs1,
                         input logic [63:0] rs2, input logic [63:0] imm_v, input logic [4:0] rd,
                         input int n_stall, input logic fl);
        for (int i = 0; i <= n_stall; i++)
        begin
            @(negedge clk);
            observe(i < n_stall);
            opcode  = opc;
            funct3  = f3;
            rs1data = rs1;
            rs2data = rs2;
            imm     = imm_v;
            pc      = pc_next;
            rdaddr  = rd;
            stall   = (i < n_stall);
            flush   = fl;
        end
        model_accept(opc, f3, rs1, rs2, imm_v, pc_next, rd, fl);
        pc_next = pc_next + 64'd4;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 8)
        begin
            issue(7'd0, 3'd0, 64'd0, 64'd0, 64'd0, 5'd0, 0, 1'b0);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d expected retirements never appeared", exp_q.size());
            err_cnt += exp_q.size();
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name);
        drain();
        $display("%s: %0d retirements, %0d errors", name, ret_cnt - ret_mark, err_cnt - err_mark);
        ret_mark = ret_cnt;
        err_mark = err_cnt;
    endtask

    task automatic alu_traffic(input int n);
        logic [31:0] r;
        logic [6:0]  opc;
        logic [4:0]  rd;
        for (int j = 0; j < n; j++)
        begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    opc = riscv_em_pkg::OPC_OP;
                2'd1:    opc = riscv_em_pkg::OPC_OPIMM;
                2'd2:    opc = riscv_em_pkg::OPC_LUI;
                default: opc = riscv_em_pkg::OPC_JAL;
            endcase
            rd = (j % 16 == 0) ? 5'd0 : r[8:4];  // x0 now and then
            issue(opc, r[11:9], {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                  {$random(seed), $random(seed)}, rd, 0, 1'b0);
        end
    endtask

    task automatic mem_traffic(input int n, input int stall_pct, input int flush_pct);
        logic [31:0] r;
        logic        is_st;
        logic [1:0]  sz;
        logic [63:0] addr;
        logic [63:0] imm_v;
        int          ns;
        for (int j = 0; j < n; j++)
        begin
            r     = $random(seed);
            is_st = r[0];
            sz    = r[2:1];
            if (!is_st && r[4])
                addr = last_st_addr;  // read back the latest store
            else
                addr = {56'd0, r[15:8]};
            addr  = addr & ~((64'd1 << sz) - 64'd1);
            imm_v = {{59{r[20]}}, r[20:16]};
            if (is_st)
                last_st_addr = addr;
            ns = chance(stall_pct) ? 1 + r[21] : 0;
            issue(is_st ? riscv_em_pkg::OPC_STORE : riscv_em_pkg::OPC_LOAD,
                  {is_st ? 1'b0 : r[3], sz}, addr - imm_v, {$random(seed), $random(seed)},
                  imm_v, r[26:22], ns, chance(flush_pct));
        end
    endtask

    task automatic misaligned_traffic(input int n);
        logic [31:0] r;
        logic        is_st;
        logic [1:0]  sz;
        logic [63:0] base;
        logic [63:0] off;
        for (int j = 0; j < n; j++)
        begin
            r     = $random(seed);
            is_st = r[0];
            sz    = (r[2:1] == 2'b00) ? 2'b01 : r[2:1];
            base  = {56'd0, r[15:11], 3'b000};
            off   = {61'd0, r[10:8]};
            if ((off & ((64'd1 << sz) - 64'd1)) == 64'd0)
                off = off | 64'd1;
            issue(is_st ? riscv_em_pkg::OPC_STORE : riscv_em_pkg::OPC_LOAD, {1'b0, sz},
                  base + off, {$random(seed), $random(seed)}, 64'd0, r[20:16] | 5'd1, 0, 1'b0);
            // killed behind the trap
            issue(riscv_em_pkg::OPC_OP, r[23:21], {$random(seed), $random(seed)},
                  {$random(seed), $random(seed)}, 64'd0, r[28:24] | 5'd1, 0, 1'b0);
            issue(riscv_em_pkg::OPC_LOAD, 3'b011, base, 64'd0, 64'd0, 5'd7, 0, 1'b0);
        end
    endtask

    initial
    begin : watchdog
        while (cycle_cnt < CYCLE_LIMIT)
            @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        opcode       = 7'd0;
        funct3       = 3'd0;
        rs1data      = 64'd0;
        rs2data      = 64'd0;
        imm          = 64'd0;
        pc           = 64'd0;
        rdaddr       = 5'd0;
        stall        = 1'b0;
        flush        = 1'b0;
        seed         = 32'h81b8;
        cycle_cnt    = 0;
        err_cnt      = 0;
        ret_cnt      = 0;
        err_mark     = 0;
        ret_mark     = 0;
        kill_pending = 1'b0;
        pc_next      = 64'h1000;
        last_st_addr = 64'd0;
        for (int i = 0; i < 512; i++)
            ref_mem[i] = 8'h00;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 3; i++)
        begin
            @(negedge clk);
            check_val("retire after reset", retire, 64'd0);
            check_val("regw after reset", regw, 64'd0);
            check_val("trap after reset", trap, 64'd0);
        end
        report_test("test 1 reset state");

        alu_traffic(200);
        report_test("test 2 alu, lui, jal");
        mem_traffic(200, 0, 0);
        report_test("test 3 aligned loads and stores");
        misaligned_traffic(40);
        report_test("test 4 misaligned traps");
        mem_traffic(200, 25, 15);
        report_test("test 5 stall and flush");

        $display("summary: %0d retirements checked, %0d errors", ret_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/riscv_em_pkg.sv
package riscv_em_pkg;

    localparam int XLEN = 64;

    // major opcodes handled by this slice of the pipeline
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;

    // funct3[1:0] of loads and stores, funct3[2] means zero extend
    localparam logic [1:0] SZ_B = 2'b00;
    localparam logic [1:0] SZ_H = 2'b01;
    localparam logic [1:0] SZ_W = 2'b10;
    localparam logic [1:0] SZ_D = 2'b11;

    localparam logic [1:0] RES_ALU = 2'b00;
    localparam logic [1:0] RES_MEM = 2'b01;
    localparam logic [1:0] RES_PC4 = 2'b10;
    localparam logic [1:0] RES_IMM = 2'b11;

    localparam logic [3:0] CAUSE_LOAD_MISALIGNED  = 4'd4;
    localparam logic [3:0] CAUSE_STORE_MISALIGNED = 4'd6;

    typedef struct packed {
        logic            valid;
        logic            regw;
        logic [1:0]      resultsrc;
        logic [2:0]      memext;    // load funct3
        logic [1:0]      storesrc;  // store size
        logic            is_load;
        logic            is_store;
        logic            load_misaligned;
        logic            store_misaligned;
        logic [4:0]      rdaddr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pcplus4;
        logic [XLEN-1:0] result;    // alu value or memory address
        logic [XLEN-1:0] storedata;
        logic [XLEN-1:0] imm;
    } em_payload_t;

    typedef struct packed {
        logic            valid;
        logic            regw;
        logic [1:0]      resultsrc;
        logic [4:0]      rdaddr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pcplus4;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] loaddata;
        logic [XLEN-1:0] imm;
        logic            trap;
        logic [3:0]      cause;
    } mw_payload_t;

endpackage

//--- verilog/riscv_em_top.sv
`timescale 1ns/1ps

module riscv_em_top #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          i_riscv_em_clk,
    input  logic                          i_riscv_em_rst,
    input  logic [6:0]                    i_riscv_em_opcode,
    input  logic [2:0]                    i_riscv_em_funct3,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_rs1data,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_rs2data,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_imm,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_pc,
    input  logic [4:0]                    i_riscv_em_rdaddr,
    input  logic                          i_riscv_em_stall,
    input  logic                          i_riscv_em_flush,
    output logic                          o_riscv_em_retire,
    output logic                          o_riscv_em_regw,
    output logic [4:0]                    o_riscv_em_rdaddr,
    output logic [riscv_em_pkg::XLEN-1:0] o_riscv_em_rddata,
    output logic                          o_riscv_em_trap,
    output logic [3:0]                    o_riscv_em_cause,
    output logic [riscv_em_pkg::XLEN-1:0] o_riscv_em_pc
);

    riscv_em_pkg::em_payload_t ex_payload;
    riscv_em_pkg::em_payload_t em_payload;
    riscv_em_pkg::mw_payload_t mem_payload;
    riscv_em_pkg::mw_payload_t mw_payload;
    logic                      mem_kill;

    riscv_exec_stage u_exec (
        .i_riscv_em_opcode  (i_riscv_em_opcode),
        .i_riscv_em_funct3  (i_riscv_em_funct3),
        .i_riscv_em_rs1data (i_riscv_em_rs1data),
        .i_riscv_em_rs2data (i_riscv_em_rs2data),
        .i_riscv_em_imm     (i_riscv_em_imm),
        .i_riscv_em_pc      (i_riscv_em_pc),
        .i_riscv_em_rdaddr  (i_riscv_em_rdaddr),
        .i_riscv_em_flush   (i_riscv_em_flush),
        .i_riscv_em_kill    (mem_kill),
        .o_riscv_em_payload (ex_payload)
    );

    riscv_ppreg #(.payload_t(riscv_em_pkg::em_payload_t)) u_em (
        .i_riscv_em_clk   (i_riscv_em_clk),
        .i_riscv_em_rst   (i_riscv_em_rst),
        .i_riscv_em_stall (i_riscv_em_stall),
        .i_riscv_em_d     (ex_payload),
        .o_riscv_em_q     (em_payload)
    );

    riscv_mem_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_mem (
        .i_riscv_em_clk     (i_riscv_em_clk),
        .i_riscv_em_rst     (i_riscv_em_rst),
        .i_riscv_em_stall   (i_riscv_em_stall),
        .i_riscv_em_payload (em_payload),
        .o_riscv_em_payload (mem_payload),
        .o_riscv_em_kill    (mem_kill)
    );

    riscv_ppreg #(.payload_t(riscv_em_pkg::mw_payload_t)) u_mw (
        .i_riscv_em_clk   (i_riscv_em_clk),
        .i_riscv_em_rst   (i_riscv_em_rst),
        .i_riscv_em_stall (i_riscv_em_stall),
        .i_riscv_em_d     (mem_payload),
        .o_riscv_em_q     (mw_payload)
    );

    riscv_wb_stage u_wb (
        .i_riscv_em_payload (mw_payload),
        .o_riscv_em_retire  (o_riscv_em_retire),
        .o_riscv_em_regw    (o_riscv_em_regw),
        .o_riscv_em_rdaddr  (o_riscv_em_rdaddr),
        .o_riscv_em_rddata  (o_riscv_em_rddata),
        .o_riscv_em_trap    (o_riscv_em_trap),
        .o_riscv_em_cause   (o_riscv_em_cause),
        .o_riscv_em_pc      (o_riscv_em_pc)
    );

endmodule

//--- verilog/riscv_exec_stage.sv
`timescale 1ns/1ps

module riscv_exec_stage (
    input  logic [6:0]                      i_riscv_em_opcode,
    input  logic [2:0]                      i_riscv_em_funct3,
    input  logic [riscv_em_pkg::XLEN-1:0]   i_riscv_em_rs1data,
    input  logic [riscv_em_pkg::XLEN-1:0]   i_riscv_em_rs2data,
    input  logic [riscv_em_pkg::XLEN-1:0]   i_riscv_em_imm,
    input  logic [riscv_em_pkg::XLEN-1:0]   i_riscv_em_pc,
    input  logic [4:0]                      i_riscv_em_rdaddr,
    input  logic                            i_riscv_em_flush,
    input  logic                            i_riscv_em_kill,
    output riscv_em_pkg::em_payload_t       o_riscv_em_payload
);

    logic                          is_op;
    logic                          is_opimm;
    logic                          is_load;
    logic                          is_store;
    logic                          is_lui;
    logic                          is_jal;
    logic                          known;
    logic [riscv_em_pkg::XLEN-1:0] op_b;
    logic [5:0]                    shamt;
    logic [riscv_em_pkg::XLEN-1:0] alu_res;
    logic [riscv_em_pkg::XLEN-1:0] addr;
    logic                          misal;

    assign is_op    = (i_riscv_em_opcode == riscv_em_pkg::OPC_OP);
    assign is_opimm = (i_riscv_em_opcode == riscv_em_pkg::OPC_OPIMM);
    assign is_load  = (i_riscv_em_opcode == riscv_em_pkg::OPC_LOAD);
    assign is_store = (i_riscv_em_opcode == riscv_em_pkg::OPC_STORE);
    assign is_lui   = (i_riscv_em_opcode == riscv_em_pkg::OPC_LUI);
    assign is_jal   = (i_riscv_em_opcode == riscv_em_pkg::OPC_JAL);
    assign known    = is_op | is_opimm | is_load | is_store | is_lui | is_jal;

    assign op_b  = is_op ? i_riscv_em_rs2data : i_riscv_em_imm;
    assign shamt = op_b[5:0];
    assign addr  = i_riscv_em_rs1data + i_riscv_em_imm;

    always_comb
    begin
        case (i_riscv_em_funct3)
            3'b000:  alu_res = i_riscv_em_rs1data + op_b;
            3'b001:  alu_res = i_riscv_em_rs1data << shamt;
            3'b010:  alu_res = {{(riscv_em_pkg::XLEN-1){1'b0}},
                                $signed(i_riscv_em_rs1data) < $signed(op_b)};
            3'b011:  alu_res = {{(riscv_em_pkg::XLEN-1){1'b0}}, i_riscv_em_rs1data < op_b};
            3'b100:  alu_res = i_riscv_em_rs1data ^ op_b;
            3'b101:  alu_res = i_riscv_em_rs1data >> shamt;  // logical only
            3'b110:  alu_res = i_riscv_em_rs1data | op_b;
            default: alu_res = i_riscv_em_rs1data & op_b;
        endcase
    end

    // natural alignment against the access size
    always_comb
    begin
        case (i_riscv_em_funct3[1:0])
            riscv_em_pkg::SZ_B: misal = 1'b0;
            riscv_em_pkg::SZ_H: misal = addr[0];
            riscv_em_pkg::SZ_W: misal = |addr[1:0];
            default:            misal = |addr[2:0];
        endcase
    end

    always_comb
    begin
        o_riscv_em_payload                  = '0;
        o_riscv_em_payload.valid            = 1'b1;
        o_riscv_em_payload.regw             = ~is_store;
        if (is_load)
            o_riscv_em_payload.resultsrc = riscv_em_pkg::RES_MEM;
        else if (is_jal)
            o_riscv_em_payload.resultsrc = riscv_em_pkg::RES_PC4;
        else if (is_lui)
            o_riscv_em_payload.resultsrc = riscv_em_pkg::RES_IMM;
        else
            o_riscv_em_payload.resultsrc = riscv_em_pkg::RES_ALU;
        o_riscv_em_payload.memext           = i_riscv_em_funct3;
        o_riscv_em_payload.storesrc         = i_riscv_em_funct3[1:0];
        o_riscv_em_payload.is_load          = is_load;
        o_riscv_em_payload.is_store         = is_store;
        o_riscv_em_payload.load_misaligned  = is_load & misal;
        o_riscv_em_payload.store_misaligned = is_store & misal;
        o_riscv_em_payload.rdaddr           = is_store ? 5'd0 : i_riscv_em_rdaddr;
        o_riscv_em_payload.pc               = i_riscv_em_pc;
        o_riscv_em_payload.pcplus4          = i_riscv_em_pc + 'd4;
        o_riscv_em_payload.result           = (is_load | is_store) ? addr : alu_res;
        o_riscv_em_payload.storedata        = i_riscv_em_rs2data;
        o_riscv_em_payload.imm              = i_riscv_em_imm;
        if (i_riscv_em_flush || i_riscv_em_kill || !known)
            o_riscv_em_payload = '0;  // bubble
    end

endmodule

//--- verilog/riscv_mem_stage.sv
`timescale 1ns/1ps

module riscv_mem_stage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                      i_riscv_em_clk,
    input  logic                      i_riscv_em_rst,
    input  logic                      i_riscv_em_stall,
    input  riscv_em_pkg::em_payload_t i_riscv_em_payload,
    output riscv_em_pkg::mw_payload_t o_riscv_em_payload,
    output logic                      o_riscv_em_kill
);

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    logic [riscv_em_pkg::XLEN-1:0] mem [DMEM_DEPTH];
    logic [IDX_W-1:0]              mem_idx;
    logic [2:0]                    byte_off;
    logic [riscv_em_pkg::XLEN-1:0] rd_word;
    logic [riscv_em_pkg::XLEN-1:0] rd_shift;
    logic [riscv_em_pkg::XLEN-1:0] load_val;
    logic [riscv_em_pkg::XLEN-1:0] wr_data;
    logic [riscv_em_pkg::XLEN-1:0] wr_word;
    logic [7:0]                    byte_en;
    logic                          trap;
    logic                          mem_we;

    // doubleword index wraps at the array size
    assign mem_idx  = i_riscv_em_payload.result[IDX_W+2:3];
    assign byte_off = i_riscv_em_payload.result[2:0];
    assign rd_word  = mem[mem_idx];
    assign rd_shift = rd_word >> {byte_off, 3'b000};

    always_comb
    begin
        case (i_riscv_em_payload.memext[1:0])
            riscv_em_pkg::SZ_B:
                load_val = i_riscv_em_payload.memext[2] ? {56'd0, rd_shift[7:0]} :
                                                          {{56{rd_shift[7]}}, rd_shift[7:0]};
            riscv_em_pkg::SZ_H:
                load_val = i_riscv_em_payload.memext[2] ? {48'd0, rd_shift[15:0]} :
                                                          {{48{rd_shift[15]}}, rd_shift[15:0]};
            riscv_em_pkg::SZ_W:
                load_val = i_riscv_em_payload.memext[2] ? {32'd0, rd_shift[31:0]} :
                                                          {{32{rd_shift[31]}}, rd_shift[31:0]};
            default:
                load_val = rd_shift;
        endcase
    end

    always_comb
    begin
        case (i_riscv_em_payload.storesrc)
            riscv_em_pkg::SZ_B: byte_en = 8'h01 << byte_off;
            riscv_em_pkg::SZ_H: byte_en = 8'h03 << byte_off;
            riscv_em_pkg::SZ_W: byte_en = 8'h0f << byte_off;
            default:            byte_en = 8'hff;
        endcase
    end

    assign wr_data = i_riscv_em_payload.storedata << {byte_off, 3'b000};

    // little-endian lane merge with the current doubleword
    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            wr_word[8*i +: 8] = byte_en[i] ? wr_data[8*i +: 8] : rd_word[8*i +: 8];
        end
    end

    assign trap   = i_riscv_em_payload.load_misaligned | i_riscv_em_payload.store_misaligned;
    assign mem_we = i_riscv_em_payload.is_store & ~i_riscv_em_payload.store_misaligned &
                    ~i_riscv_em_stall;

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            for (int i = 0; i < DMEM_DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (mem_we)
        begin
            mem[mem_idx] <= wr_word;  // commits as the store moves to MW
        end
    end

    always_comb
    begin
        o_riscv_em_payload.valid     = i_riscv_em_payload.valid;
        o_riscv_em_payload.regw      = i_riscv_em_payload.regw & ~trap;
        o_riscv_em_payload.resultsrc = i_riscv_em_payload.resultsrc;
        o_riscv_em_payload.rdaddr    = i_riscv_em_payload.rdaddr;
        o_riscv_em_payload.pc        = i_riscv_em_payload.pc;
        o_riscv_em_payload.pcplus4   = i_riscv_em_payload.pcplus4;
        o_riscv_em_payload.result    = i_riscv_em_payload.result;
        o_riscv_em_payload.loaddata  = load_val;
        o_riscv_em_payload.imm       = i_riscv_em_payload.imm;
        o_riscv_em_payload.trap      = trap;
        if (i_riscv_em_payload.load_misaligned)
            o_riscv_em_payload.cause = riscv_em_pkg::CAUSE_LOAD_MISALIGNED;
        else if (i_riscv_em_payload.store_misaligned)
            o_riscv_em_payload.cause = riscv_em_pkg::CAUSE_STORE_MISALIGNED;
        else
            o_riscv_em_payload.cause = 4'd0;
    end

    assign o_riscv_em_kill = trap;  // squash the instruction entering behind

    // addressed doubleword keeps its old value across a misaligned access
    a_no_trap_write : assert property (
        @(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        trap |=> mem[$past(mem_idx)] == $past(rd_word)
    ) else $error("memory modified by a misaligned access");

endmodule

//--- verilog/riscv_ppreg.sv
`timescale 1ns/1ps

module riscv_ppreg #(
    parameter type payload_t = logic
) (
    input  logic     i_riscv_em_clk,
    input  logic     i_riscv_em_rst,
    input  logic     i_riscv_em_stall,
    input  payload_t i_riscv_em_d,
    output payload_t o_riscv_em_q
);

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            o_riscv_em_q <= '0;
        end
        else if (!i_riscv_em_stall)
        begin
            o_riscv_em_q <= i_riscv_em_d;
        end
    end

    // a stalled edge must leave the stage contents untouched
    a_hold_on_stall : assert property (
        @(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_riscv_em_stall |=> $stable(o_riscv_em_q)
    ) else $error("pipeline register changed while stalled");

endmodule

//--- verilog/riscv_wb_stage.sv
`timescale 1ns/1ps

module riscv_wb_stage (
    input  riscv_em_pkg::mw_payload_t     i_riscv_em_payload,
    output logic                          o_riscv_em_retire,
    output logic                          o_riscv_em_regw,
    output logic [4:0]                    o_riscv_em_rdaddr,
    output logic [riscv_em_pkg::XLEN-1:0] o_riscv_em_rddata,
    output logic                          o_riscv_em_trap,
    output logic [3:0]                    o_riscv_em_cause,
    output logic [riscv_em_pkg::XLEN-1:0] o_riscv_em_pc
);

    always_comb
    begin
        case (i_riscv_em_payload.resultsrc)
            riscv_em_pkg::RES_MEM: o_riscv_em_rddata = i_riscv_em_payload.loaddata;
            riscv_em_pkg::RES_PC4: o_riscv_em_rddata = i_riscv_em_payload.pcplus4;
            riscv_em_pkg::RES_IMM: o_riscv_em_rddata = i_riscv_em_payload.imm;
            default:               o_riscv_em_rddata = i_riscv_em_payload.result;
        endcase
    end

    assign o_riscv_em_retire = i_riscv_em_payload.valid;
    // x0 is never written
    assign o_riscv_em_regw   = i_riscv_em_payload.valid & i_riscv_em_payload.regw &
                               (i_riscv_em_payload.rdaddr != 5'd0);
    assign o_riscv_em_rdaddr = i_riscv_em_payload.rdaddr;
    assign o_riscv_em_trap   = i_riscv_em_payload.trap;
    assign o_riscv_em_cause  = i_riscv_em_payload.cause;
    assign o_riscv_em_pc     = i_riscv_em_payload.pc;

    // trap suppression of regw happens back in the memory stage
    always_comb
    begin
        a_trap_no_regw : assert final (!(o_riscv_em_trap && o_riscv_em_regw))
            else $error("register write on a trapping instruction");
    end

endmodule

//--- vlog.f
verilog/riscv_em_pkg.sv
verilog/riscv_exec_stage.sv
verilog/riscv_ppreg.sv
verilog/riscv_mem_stage.sv
verilog/riscv_wb_stage.sv
verilog/riscv_em_top.sv
verification/riscv_em_tb.sv
